//--- flist.f
+incdir+src
src/isaPkg.sv
src/ctrlPkg.sv
src/instrDecoder.sv
src/mainSequencer.sv
src/controlWordGen.sv
src/controlUnit.sv
verification/controlUnit_asserts.sv
verification/controlUnit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module controlUnit_tb \
    -Mdir obj_dir -o controlUnit_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/controlUnit_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

//--- src/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defines.svh"

module controlUnit (
    input  wire                        clk,
    input  wire                        arstN,
    input  isaPkg::opcodeT             opcode,
    input  isaPkg::functT              funct,
    input  logic                       overflow,
    output logic                       pcWriteCond,
    output logic                       pcWrite,
    output logic                       eqOrNe,
    output logic                       memReadWrite,
    output logic                       irWrite,
    output logic                       regWrite,
    output logic                       regALoad,
    output logic                       regBLoad,
    output logic                       aluSrcA,
    output logic                       epcWrite,
    output logic                       aluOutWrite,
    output logic                       mdrLoad,
    output ctrlPkg::regDstT            regDst,
    output logic [`ALUSRCB_W-1:0]      aluSrcB,
    output ctrlPkg::iorDT              iorD,
    output logic [`ALUOP_W-1:0]        aluOp,
    output ctrlPkg::pcSrcT             pcSrc,
    output ctrlPkg::memtoRegT          memtoReg
);

    isaPkg::instrClassT instrClass;
    ctrlPkg::stateT state;

    instrDecoder decoder_i (
        .opcode    (opcode),
        .funct     (funct),
        .instrClass(instrClass)
    );

    mainSequencer sequencer_i (
        .clk       (clk),
        .arstN     (arstN),
        .instrClass(instrClass),
        .overflow  (overflow),
        .state     (state)
    );

    // outputs lag state by one clock
    controlWordGen wordGen_i (
        .clk         (clk),
        .arstN       (arstN),
        .state       (state),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .eqOrNe      (eqOrNe),
        .memReadWrite(memReadWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .regALoad    (regALoad),
        .regBLoad    (regBLoad),
        .aluSrcA     (aluSrcA),
        .epcWrite    (epcWrite),
        .aluOutWrite (aluOutWrite),
        .mdrLoad     (mdrLoad),
        .regDst      (regDst),
        .aluSrcB     (aluSrcB),
        .iorD        (iorD),
        .aluOp       (aluOp),
        .pcSrc       (pcSrc),
        .memtoReg    (memtoReg)
    );

endmodule

`default_nettype wire

//--- src/controlWordGen.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defines.svh"

module controlWordGen (
    input  wire                        clk,
    input  wire                        arstN,
    input  ctrlPkg::stateT             state,
    output logic                       pcWriteCond,
    output logic                       pcWrite,
    output logic                       eqOrNe,
    output logic                       memReadWrite,
    output logic                       irWrite,
    output logic                       regWrite,
    output logic                       regALoad,
    output logic                       regBLoad,
    output logic                       aluSrcA,
    output logic                       epcWrite,
    output logic                       aluOutWrite,
    output logic                       mdrLoad,
    output ctrlPkg::regDstT            regDst,
    output logic [`ALUSRCB_W-1:0]      aluSrcB,
    output ctrlPkg::iorDT              iorD,
    output logic [`ALUOP_W-1:0]        aluOp,
    output ctrlPkg::pcSrcT             pcSrc,
    output ctrlPkg::memtoRegT          memtoReg
);

    localparam logic [`ALUOP_W-1:0] ALU_ADD = 3'd1;
    localparam logic [`ALUOP_W-1:0] ALU_SUB = 3'd2;

    localparam logic [`ALUSRCB_W-1:0] SRCB_REG  = 2'd0;
    localparam logic [`ALUSRCB_W-1:0] SRCB_FOUR = 2'd1;
    localparam logic [`ALUSRCB_W-1:0] SRCB_IMM  = 2'd2;
    localparam logic [`ALUSRCB_W-1:0] SRCB_OFS  = 2'd3; // shifted offset for branches

    logic pcWriteCondNxt, pcWriteNxt, eqOrNeNxt, memReadWriteNxt, irWriteNxt;
    logic regWriteNxt, regALoadNxt, regBLoadNxt, aluSrcANxt, epcWriteNxt;
    logic aluOutWriteNxt, mdrLoadNxt;
    logic [`ALUSRCB_W-1:0] aluSrcBNxt;
    logic [`ALUOP_W-1:0] aluOpNxt;
    ctrlPkg::regDstT regDstNxt;
    ctrlPkg::iorDT iorDNxt;
    ctrlPkg::pcSrcT pcSrcNxt;
    ctrlPkg::memtoRegT memtoRegNxt;

    always_comb begin
        pcWriteCondNxt  = 1'b0;
        pcWriteNxt      = 1'b0;
        eqOrNeNxt       = 1'b0;
        memReadWriteNxt = 1'b0; // read
        irWriteNxt      = 1'b0;
        regWriteNxt     = 1'b0;
        regALoadNxt     = 1'b0;
        regBLoadNxt     = 1'b0;
        aluSrcANxt      = 1'b0;
        epcWriteNxt     = 1'b0;
        aluOutWriteNxt  = 1'b0;
        mdrLoadNxt      = 1'b0;
        regDstNxt       = ctrlPkg::dstRt;
        aluSrcBNxt      = SRCB_REG;
        iorDNxt         = ctrlPkg::adrPc;
        aluOpNxt        = '0;
        pcSrcNxt        = ctrlPkg::pcAlu;
        memtoRegNxt     = ctrlPkg::wbAluOut;

        case (state)
            ctrlPkg::stResetInit: begin
                regWriteNxt = 1'b1;
                regDstNxt   = ctrlPkg::dstSp;
                memtoRegNxt = ctrlPkg::wbSpInit;
            end
            ctrlPkg::stFetch: begin
                pcWriteNxt = 1'b1; // pc + 4
                aluSrcBNxt = SRCB_FOUR;
                aluOpNxt   = ALU_ADD;
            end
            ctrlPkg::stIrLoad: irWriteNxt = 1'b1;
            ctrlPkg::stDecode: begin
                regALoadNxt    = 1'b1;
                regBLoadNxt    = 1'b1;
                aluSrcBNxt     = SRCB_OFS; // branch target into aluOut
                aluOpNxt       = ALU_ADD;
                aluOutWriteNxt = 1'b1;
            end
            ctrlPkg::stAddExec: begin
                aluSrcANxt     = 1'b1;
                aluOpNxt       = ALU_ADD;
                aluOutWriteNxt = 1'b1;
            end
            ctrlPkg::stImmExec, ctrlPkg::stMemAddr: begin
                aluSrcANxt     = 1'b1;
                aluSrcBNxt     = SRCB_IMM;
                aluOpNxt       = ALU_ADD;
                aluOutWriteNxt = 1'b1;
            end
            ctrlPkg::stAddWb: begin
                regWriteNxt = 1'b1;
                regDstNxt   = ctrlPkg::dstRd;
            end
            ctrlPkg::stImmWb: regWriteNxt = 1'b1;
            ctrlPkg::stLwRead, ctrlPkg::stLwWait: iorDNxt = ctrlPkg::adrAluOut;
            ctrlPkg::stLwMdr: begin
                iorDNxt    = ctrlPkg::adrAluOut;
                mdrLoadNxt = 1'b1;
            end
            ctrlPkg::stLwWb: begin
                regWriteNxt = 1'b1;
                memtoRegNxt = ctrlPkg::wbMdr;
            end
            ctrlPkg::stSwWrite: begin
                iorDNxt         = ctrlPkg::adrAluOut;
                memReadWriteNxt = 1'b1;
            end
            ctrlPkg::stBranchCmp, ctrlPkg::stBranchEq, ctrlPkg::stBranchNe: begin
                // compare rs and rt, zero flag decides
                aluSrcANxt     = 1'b1;
                aluOpNxt       = ALU_SUB;
                pcSrcNxt       = ctrlPkg::pcAluOut;
                pcWriteCondNxt = (state != ctrlPkg::stBranchCmp);
                eqOrNeNxt      = (state == ctrlPkg::stBranchEq);
            end
            ctrlPkg::stJalLink: begin
                regWriteNxt = 1'b1;
                regDstNxt   = ctrlPkg::dstRa;
                memtoRegNxt = ctrlPkg::wbPcLink;
            end
            ctrlPkg::stJump: begin
                pcWriteNxt = 1'b1;
                pcSrcNxt   = ctrlPkg::pcJumpTarget;
            end
            ctrlPkg::stExcOvf, ctrlPkg::stExcIll: begin
                // epc gets pc - 4
                epcWriteNxt = 1'b1;
                aluSrcBNxt  = SRCB_FOUR;
                aluOpNxt    = ALU_SUB;
                if (state == ctrlPkg::stExcOvf) begin
                    iorDNxt = ctrlPkg::adrOvfVec;
                end else begin
                    iorDNxt = ctrlPkg::adrIllVec;
                end
            end
            ctrlPkg::stExcWait: iorDNxt = iorD; // keep vector address on the bus
            ctrlPkg::stExcMdr: begin
                iorDNxt    = iorD;
                mdrLoadNxt = 1'b1;
            end
            ctrlPkg::stExcVector: begin
                pcWriteNxt = 1'b1;
                pcSrcNxt   = ctrlPkg::pcExcVector;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // stack pointer init word
            pcWriteCond  <= 1'b0;
            pcWrite      <= 1'b0;
            eqOrNe       <= 1'b0;
            memReadWrite <= 1'b0;
            irWrite      <= 1'b0;
            regWrite     <= 1'b1;
            regALoad     <= 1'b0;
            regBLoad     <= 1'b0;
            aluSrcA      <= 1'b0;
            epcWrite     <= 1'b0;
            aluOutWrite  <= 1'b0;
            mdrLoad      <= 1'b0;
            regDst       <= ctrlPkg::dstSp;
            aluSrcB      <= SRCB_REG;
            iorD         <= ctrlPkg::adrPc;
            aluOp        <= '0;
            pcSrc        <= ctrlPkg::pcAlu;
            memtoReg     <= ctrlPkg::wbSpInit;
        end else begin
            pcWriteCond  <= pcWriteCondNxt;
            pcWrite      <= pcWriteNxt;
            eqOrNe       <= eqOrNeNxt;
            memReadWrite <= memReadWriteNxt;
            irWrite      <= irWriteNxt;
            regWrite     <= regWriteNxt;
            regALoad     <= regALoadNxt;
            regBLoad     <= regBLoadNxt;
            aluSrcA      <= aluSrcANxt;
            epcWrite     <= epcWriteNxt;
            aluOutWrite  <= aluOutWriteNxt;
            mdrLoad      <= mdrLoadNxt;
            regDst       <= regDstNxt;
            aluSrcB      <= aluSrcBNxt;
            iorD         <= iorDNxt;
            aluOp        <= aluOpNxt;
            pcSrc        <= pcSrcNxt;
            memtoReg     <= memtoRegNxt;
        end
    end

endmodule

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

`include "ctrl_defines.svh"

package ctrlPkg;

    typedef enum logic [4:0] {
        stResetInit,
        stFetch,
        stFetchWait,
        stIrLoad,
        stDecode,
        stAddExec,
        stAddWb,
        stImmExec,
        stImmWb,
        stMemAddr,
        stLwRead,
        stLwWait,
        stLwMdr,
        stLwWb,
        stSwWrite,
        stBranchCmp,
        stBranchEq,
        stBranchNe,
        stJalLink,
        stJump,
        stExcOvf,
        stExcIll,
        stExcWait,
        stExcMdr,
        stExcVector
    } stateT;

    typedef enum logic [`PCSRC_W-1:0] {
        pcAlu        = 2'd0,
        pcAluOut     = 2'd1,
        pcJumpTarget = 2'd2,
        pcExcVector  = 2'd3
    } pcSrcT;

    // encodings follow the datapath write-back mux
    typedef enum logic [`MEMTOREG_W-1:0] {
        wbAluOut = 4'd0,
        wbMdr    = 4'd1,
        wbPcLink = 4'd6,
        wbSpInit = 4'd7
    } memtoRegT;

    typedef enum logic [`REGDST_W-1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2,
        dstSp = 2'd3
    } regDstT;

    typedef enum logic [`IORD_W-1:0] {
        adrPc     = 2'd0,
        adrAluOut = 2'd1,
        adrIllVec = 2'd2,
        adrOvfVec = 2'd3
    } iorDT;

endpackage

`default_nettype wire

//--- src/ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// datapath control line widths
`define ALUOP_W 3
`define IORD_W 2
`define PCSRC_W 2
`define MEMTOREG_W 4
`define REGDST_W 2
`define ALUSRCB_W 2

`endif

//--- src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  isaPkg::opcodeT     opcode,
    input  isaPkg::functT      funct,
    output isaPkg::instrClassT instrClass
);

    always_comb begin
        case (opcode)
            isaPkg::OP_RTYPE: begin
                // add is the only R-type left
                if (funct == isaPkg::FN_ADD) begin
                    instrClass = isaPkg::clsAdd;
                end else begin
                    instrClass = isaPkg::clsIllegal;
                end
            end
            isaPkg::OP_ADDI:  instrClass = isaPkg::clsAddi;
            isaPkg::OP_ADDIU: instrClass = isaPkg::clsAddiu;
            isaPkg::OP_LW:    instrClass = isaPkg::clsLw;
            isaPkg::OP_SW:    instrClass = isaPkg::clsSw;
            isaPkg::OP_BEQ:   instrClass = isaPkg::clsBeq;
            isaPkg::OP_BNE:   instrClass = isaPkg::clsBne;
            isaPkg::OP_J:     instrClass = isaPkg::clsJ;
            isaPkg::OP_JAL:   instrClass = isaPkg::clsJal;
            default:          instrClass = isaPkg::clsIllegal; // undefined opcode
        endcase
    end

endmodule

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

`include "ctrl_defines.svh"

package isaPkg;

    typedef logic [`OPCODE_W-1:0] opcodeT;
    typedef logic [`FUNCT_W-1:0] functT;

    // opcodes
    localparam opcodeT OP_RTYPE = 6'h00;
    localparam opcodeT OP_J     = 6'h02;
    localparam opcodeT OP_JAL   = 6'h03;
    localparam opcodeT OP_BEQ   = 6'h04;
    localparam opcodeT OP_BNE   = 6'h05;
    localparam opcodeT OP_ADDI  = 6'h08;
    localparam opcodeT OP_ADDIU = 6'h09;
    localparam opcodeT OP_LW    = 6'h23;
    localparam opcodeT OP_SW    = 6'h2b;

    localparam functT FN_ADD = 6'h20; // only R-type kept

    typedef enum logic [3:0] {
        clsAdd,
        clsAddi,
        clsAddiu,
        clsLw,
        clsSw,
        clsBeq,
        clsBne,
        clsJ,
        clsJal,
        clsIllegal
    } instrClassT;

endpackage

`default_nettype wire

//--- src/mainSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module mainSequencer (
    input  wire                clk,
    input  wire                arstN,
    input  isaPkg::instrClassT instrClass,
    input  logic               overflow,
    output ctrlPkg::stateT     state
);

    ctrlPkg::stateT nextState;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ctrlPkg::stResetInit;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = ctrlPkg::stFetch; // last state of every path
        case (state)
            ctrlPkg::stResetInit: nextState = ctrlPkg::stFetch;
            ctrlPkg::stFetch:     nextState = ctrlPkg::stFetchWait;
            ctrlPkg::stFetchWait: nextState = ctrlPkg::stIrLoad;
            ctrlPkg::stIrLoad:    nextState = ctrlPkg::stDecode;

            ctrlPkg::stDecode: begin
                case (instrClass)
                    isaPkg::clsAdd:   nextState = ctrlPkg::stAddExec;
                    isaPkg::clsAddi:  nextState = ctrlPkg::stImmExec;
                    isaPkg::clsAddiu: nextState = ctrlPkg::stImmExec;
                    isaPkg::clsLw:    nextState = ctrlPkg::stMemAddr;
                    isaPkg::clsSw:    nextState = ctrlPkg::stMemAddr;
                    isaPkg::clsBeq:   nextState = ctrlPkg::stBranchCmp;
                    isaPkg::clsBne:   nextState = ctrlPkg::stBranchCmp;
                    isaPkg::clsJ:     nextState = ctrlPkg::stJump;
                    isaPkg::clsJal:   nextState = ctrlPkg::stJalLink;
                    default:          nextState = ctrlPkg::stExcIll;
                endcase
            end

            ctrlPkg::stAddExec: begin
                if (overflow) begin
                    nextState = ctrlPkg::stExcOvf;
                end else begin
                    nextState = ctrlPkg::stAddWb;
                end
            end

            ctrlPkg::stImmExec: begin
                // addiu ignores overflow
                if (overflow && instrClass == isaPkg::clsAddi) begin
                    nextState = ctrlPkg::stExcOvf;
                end else begin
                    nextState = ctrlPkg::stImmWb;
                end
            end

            ctrlPkg::stMemAddr: begin
                if (instrClass == isaPkg::clsSw) begin
                    nextState = ctrlPkg::stSwWrite;
                end else begin
                    nextState = ctrlPkg::stLwRead;
                end
            end
            ctrlPkg::stLwRead: nextState = ctrlPkg::stLwWait;
            ctrlPkg::stLwWait: nextState = ctrlPkg::stLwMdr;
            ctrlPkg::stLwMdr:  nextState = ctrlPkg::stLwWb;

            ctrlPkg::stBranchCmp: begin
                if (instrClass == isaPkg::clsBeq) begin
                    nextState = ctrlPkg::stBranchEq;
                end else begin
                    nextState = ctrlPkg::stBranchNe;
                end
            end

            ctrlPkg::stJalLink: nextState = ctrlPkg::stJump;

            // both exception causes share the vector fetch
            ctrlPkg::stExcOvf: nextState = ctrlPkg::stExcWait;
            ctrlPkg::stExcIll: nextState = ctrlPkg::stExcWait;
            ctrlPkg::stExcWait: nextState = ctrlPkg::stExcMdr;
            ctrlPkg::stExcMdr:  nextState = ctrlPkg::stExcVector;

            default: nextState = ctrlPkg::stFetch;
        endcase
    end

endmodule

`default_nettype wire

//--- verification/controlUnit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit_asserts (
    input wire            clk,
    input wire            arstN,
    input logic           pcWrite,
    input logic           pcWriteCond,
    input logic           epcWrite,
    input ctrlPkg::pcSrcT pcSrc
);

    // fetch pulse is a single cycle
    fetchPulseA: assert property (@(posedge clk) disable iff (!arstN)
        $past(pcWrite && pcSrc == ctrlPkg::pcAlu) |-> !pcWrite)
        else $error("fetch pcWrite held for more than one cycle");

    // jump or vector write is followed directly by the fetch pulse, never longer
    redirectA: assert property (@(posedge clk) disable iff (!arstN)
        $past(pcWrite && pcSrc != ctrlPkg::pcAlu) |-> (pcWrite && pcSrc == ctrlPkg::pcAlu))
        else $error("pcWrite after a redirect is not a single fetch pulse");

    exclusiveA: assert property (@(posedge clk) disable iff (!arstN)
        !(pcWrite && pcWriteCond))
        else $error("pcWrite and pcWriteCond high together");

    epcToVectorA: assert property (@(posedge clk) disable iff (!arstN)
        $past(epcWrite, 3) |-> (pcWrite && pcSrc == ctrlPkg::pcExcVector))
        else $error("no vector pcWrite three cycles after epcWrite");

endmodule

bind controlUnit controlUnit_asserts asserts_i (
    .clk        (clk),
    .arstN      (arstN),
    .pcWrite    (pcWrite),
    .pcWriteCond(pcWriteCond),
    .epcWrite   (epcWrite),
    .pcSrc      (pcSrc)
);

`default_nettype wire

//--- verification/controlUnit_patterns.txt
# name opcode(hex) funct(hex) overflow cycles regDst memtoReg finalPcSrc
# regDst and memtoReg hold -1 where no register is written
add        00 20 0 6  1  0 0
addi       08 00 0 6  0  0 0
addiu      09 00 0 6  0  0 0
addiuOvf   09 00 1 6  0  0 0
lw         23 00 0 9  0  1 0
sw         2b 00 0 6 -1 -1 0
beq        04 00 0 6 -1 -1 1
bne        05 00 0 6 -1 -1 1
j          02 00 0 5 -1 -1 2
jal        03 00 0 6  2  6 2
illegalOp  3f 00 0 8 -1 -1 3
illegalFn  00 22 0 8 -1 -1 3
addOvf     00 20 1 9 -1 -1 3
addiOvf    08 00 1 9 -1 -1 3
lwAgain    23 00 0 9  0  1 0
addLast    00 20 0 6  1  0 0

//--- verification/controlUnit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "ctrl_defines.svh"

module controlUnit_tb;

    localparam int MAX_TESTS = 32;
    localparam int RESET_CYCLES = 5;
    localparam int FETCH_AFTER_RESET = 3; // negedge samples from release to first fetch pulse
    localparam int IRWRITE_AFTER_FETCH = 2; // fetch wait comes first

    logic clk;
    logic arstN;
    isaPkg::opcodeT opcode;
    isaPkg::functT funct;
    logic overflow;

    logic pcWriteCond, pcWrite, eqOrNe, memReadWrite, irWrite, regWrite;
    logic regALoad, regBLoad, aluSrcA, epcWrite, aluOutWrite, mdrLoad;
    ctrlPkg::regDstT regDst;
    logic [`ALUSRCB_W-1:0] aluSrcB;
    ctrlPkg::iorDT iorD;
    logic [`ALUOP_W-1:0] aluOp;
    ctrlPkg::pcSrcT pcSrc;
    ctrlPkg::memtoRegT memtoReg;

    // pattern table
    string names [MAX_TESTS];
    isaPkg::opcodeT opcodes [MAX_TESTS];
    isaPkg::functT functs [MAX_TESTS];
    logic ovfs [MAX_TESTS];
    int expCycles [MAX_TESTS];
    int expDst [MAX_TESTS]; // -1 means no regWrite
    int expWb [MAX_TESTS];
    int expPcSrc [MAX_TESTS];

    int numTests;
    int cycleLimit;
    int cycleCount;
    int checkCount;
    int errorCount;

    controlUnit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic printCounts;
        $display("checks %0d, errors %0d", checkCount, errorCount);
    endtask

    task automatic checkValue(input string testName, input string what,
                              input int expVal, input int actVal);
        checkCount++;
        assert (expVal == actVal) else begin
            $display("FAILED %s %s expected %0d actual %0d", testName, what, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic readPatterns;
        int fd;
        int n;
        int ovf;
        int cyc;
        int dst;
        int wb;
        int pc;
        string line;
        string tok;
        isaPkg::opcodeT op;
        isaPkg::functT fn;
        numTests = 0;
        fd = $fopen("verification/controlUnit_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            errorCount++;
        end else begin
            while (!$feof(fd) && numTests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %d %d %d %d %d", tok, op, fn, ovf, cyc, dst, wb, pc);
                if (n == 8) begin // comment and blank lines fall through
                    names[numTests] = tok;
                    opcodes[numTests] = op;
                    functs[numTests] = fn;
                    ovfs[numTests] = (ovf != 0);
                    expCycles[numTests] = cyc;
                    expDst[numTests] = dst;
                    expWb[numTests] = wb;
                    expPcSrc[numTests] = pc;
                    cycleLimit += cyc;
                    numTests++;
                end
            end
            $fclose(fd);
        end
        if (numTests == 0) begin
            $display("no test patterns were read");
            errorCount++;
        end
    endtask

    task automatic checkSpWord(input string when);
        checkValue(when, "regWrite", 1, int'(regWrite));
        checkValue(when, "regDst", int'(ctrlPkg::dstSp), int'(regDst));
        checkValue(when, "memtoReg", int'(ctrlPkg::wbSpInit), int'(memtoReg));
        checkValue(when, "other lines", 0, int'({pcWriteCond, pcWrite, eqOrNe, memReadWrite,
            irWrite, regALoad, regBLoad, aluSrcA, epcWrite, aluOutWrite, mdrLoad, aluSrcB,
            iorD, aluOp, pcSrc}));
    endtask

    // entered right after the negedge that sampled this test's fetch pulse
    task automatic runTest(input int i);
        int cyc;
        int lastPc;
        int regWrites;
        int condWrites;
        int epcWrites;
        int mdrLoads;
        int memWrites;
        int irWrites;
        int irCyc;
        int wrCyc;
        int mdrCyc;
        int epcCyc;
        int vecCyc;
        int dstSeen;
        int wbSeen;
        int eqSeen;
        int iorSeen;
        logic done;
        logic excExpected;
        string tn;
        cyc = 0;
        lastPc = int'(ctrlPkg::pcAlu);
        regWrites = 0;
        condWrites = 0;
        epcWrites = 0;
        mdrLoads = 0;
        memWrites = 0;
        irWrites = 0;
        irCyc = 0;
        wrCyc = 0;
        mdrCyc = 0;
        epcCyc = 0;
        vecCyc = 0;
        dstSeen = -1;
        wbSeen = -1;
        eqSeen = -1;
        iorSeen = -1;
        done = 1'b0;
        tn = names[i];
        excExpected = (expPcSrc[i] == int'(ctrlPkg::pcExcVector));

        @(posedge clk);
        opcode <= opcodes[i];
        funct <= functs[i];
        overflow <= ovfs[i];

        while (!done) begin
            @(negedge clk);
            cyc++;
            if (pcWrite && pcSrc == ctrlPkg::pcAlu) begin
                done = 1'b1; // next fetch
            end else begin
                if (pcWrite || pcWriteCond) lastPc = int'(pcSrc);
                if (pcWrite) vecCyc = cyc;
                if (pcWriteCond) begin
                    condWrites++;
                    eqSeen = int'(eqOrNe);
                end
                if (irWrite) begin
                    irWrites++;
                    irCyc = cyc;
                end
                if (regWrite) begin
                    regWrites++;
                    wrCyc = cyc;
                    dstSeen = int'(regDst);
                    wbSeen = int'(memtoReg);
                end
                if (epcWrite) begin
                    epcWrites++;
                    epcCyc = cyc;
                    iorSeen = int'(iorD);
                end
                if (mdrLoad) begin
                    mdrLoads++;
                    mdrCyc = cyc;
                end
                if (memReadWrite) memWrites++;
            end
        end

        checkValue(tn, "cycles", expCycles[i], cyc);
        checkValue(tn, "irWrite pulses", 1, irWrites);
        checkValue(tn, "irWrite cycle", IRWRITE_AFTER_FETCH, irCyc);
        checkValue(tn, "regWrite pulses", int'(expDst[i] >= 0), regWrites);
        if (expDst[i] >= 0) begin
            checkValue(tn, "regDst", expDst[i], dstSeen);
            checkValue(tn, "memtoReg", expWb[i], wbSeen);
        end
        checkValue(tn, "final pcSrc", expPcSrc[i], lastPc);
        if (expPcSrc[i] == int'(ctrlPkg::pcAluOut)) begin
            checkValue(tn, "pcWriteCond pulses", 1, condWrites);
            checkValue(tn, "eqOrNe", int'(opcodes[i] == isaPkg::OP_BEQ), eqSeen);
        end else begin
            checkValue(tn, "pcWriteCond pulses", 0, condWrites);
        end
        checkValue(tn, "epcWrite pulses", int'(excExpected), epcWrites);
        checkValue(tn, "mdrLoad pulses",
                   int'(excExpected || expWb[i] == int'(ctrlPkg::wbMdr)), mdrLoads);
        if (excExpected) begin
            // overflow flag picks the vector, else it was an undefined encoding
            checkValue(tn, "vector address",
                       ovfs[i] ? int'(ctrlPkg::adrOvfVec) : int'(ctrlPkg::adrIllVec), iorSeen);
            checkValue(tn, "mdrLoad between epcWrite and vector", 1,
                       int'(mdrCyc > epcCyc && mdrCyc < vecCyc));
        end
        if (expWb[i] == int'(ctrlPkg::wbMdr)) begin
            checkValue(tn, "mdrLoad before regWrite", 1, int'(mdrCyc < wrCyc));
        end
        checkValue(tn, "memReadWrite pulses", int'(opcodes[i] == isaPkg::OP_SW), memWrites);
    endtask

    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the DUT stopped reaching the next fetch", cycleCount);
        printCounts();
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int waited;
        logic seen;
        arstN = 1'b0;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        errorCount = 0;
        checkCount = 0;
        cycleLimit = 40;
        readPatterns();

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        checkSpWord("reset");
        @(posedge clk);
        arstN <= 1'b1;

        waited = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            waited++;
            if (pcWrite) begin
                seen = 1'b1;
            end else begin
                checkSpWord("after reset");
            end
        end
        checkValue("reset", "cycles to first fetch", FETCH_AFTER_RESET, waited);
        checkValue("reset", "first fetch pcSrc", int'(ctrlPkg::pcAlu), int'(pcSrc));

        for (int i = 0; i < numTests; i++) begin
            runTest(i);
        end

        printCounts();
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
